// ==== common/tcp_pkg.sv ====
package tcp_pkg;

    typedef logic [31:0] seq_num_t;    // sequence or acknowledgement number.
    typedef logic [15:0] tcp_port_t;
    typedef logic [15:0] window_t;
    typedef logic [7:0]  tcp_flags_t;

    // one-shot commands from the connection logic.
    typedef enum logic [1:0] {
        TX_CTRL_NONE,
        TX_CTRL_SEND_SYN,
        TX_CTRL_SEND_ACK,
        TX_CTRL_SEND_FIN
    } tx_ctrl_t;

    // flags byte, bit 0 is fin.
    localparam tcp_flags_t FLAG_FIN = 8'h01;
    localparam tcp_flags_t FLAG_SYN = 8'h02;
    localparam tcp_flags_t FLAG_RST = 8'h04;
    localparam tcp_flags_t FLAG_PSH = 8'h08;
    localparam tcp_flags_t FLAG_ACK = 8'h10;
    localparam tcp_flags_t FLAG_URG = 8'h20;
    localparam tcp_flags_t FLAG_ECE = 8'h40;
    localparam tcp_flags_t FLAG_CWR = 8'h80;

    localparam int TCP_HDR_BYTES  = 20;    // no options.
    localparam int IP_TCP_HDR_LEN = 40;    // ip header plus tcp header.

endpackage

// ==== common/stream_pkg.sv ====
package stream_pkg;

    typedef logic [7:0]  byte_t;       // one stream data byte.
    typedef logic [15:0] pkt_len_t;    // payload or ip length in bytes.

endpackage

// ==== src/stream_pipe_reg.sv ====
module stream_pipe_reg (
    input  logic              i_clk,
    input  logic              i_rst,

    input  stream_pkg::byte_t i_data,
    input  logic              i_valid,
    input  logic              i_last,
    output logic              o_ready,

    output stream_pkg::byte_t o_data,
    output logic              o_valid,
    output logic              o_last,
    input  logic              i_ready
);

    stream_pkg::byte_t out_data;
    stream_pkg::byte_t skid_data;
    logic              out_valid;
    logic              out_last;
    logic              skid_valid;
    logic              skid_last;
    logic              skid_next;
    logic              in_ready;
    logic              in_xfer;
    logic              out_free;

    assign in_xfer  = i_valid && in_ready;
    assign out_free = !out_valid || i_ready;    // output slot empties this cycle.

    // skid slot only fills when the output is stalled.
    assign skid_next = out_free ? 1'b0 : (skid_valid || in_xfer);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (out_free) begin
                out_valid <= skid_valid || in_xfer;
            end
            skid_valid <= skid_next;
            in_ready   <= !skid_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : i_data;
            out_last <= skid_valid ? skid_last : i_last;
        end
        if (in_xfer && !out_free) begin
            skid_data <= i_data;
            skid_last <= i_last;
        end
    end

    assign o_ready = in_ready;
    assign o_data  = out_data;
    assign o_valid = out_valid;
    assign o_last  = out_last;

endmodule

// ==== tcp_tx/tcp_tx_ctrl.sv ====
module tcp_tx_ctrl #(
    parameter tcp_pkg::window_t WINDOW_SIZE = 16'd256
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::tx_ctrl_t    i_tx_ctrl,
    input  logic                 i_tx_ctrl_valid,
    output logic                 o_tx_ctrl_ack,

    input  tcp_pkg::seq_num_t    i_ack_number,

    input  stream_pkg::byte_t    i_s_data,
    input  logic                 i_s_valid,
    input  logic                 i_s_last,
    input  stream_pkg::pkt_len_t i_s_len,
    output logic                 o_s_ready,

    output logic                 o_no_data,
    output stream_pkg::pkt_len_t o_ip_len,
    output tcp_pkg::seq_num_t    o_seq_number,
    output tcp_pkg::seq_num_t    o_ack_number,
    output tcp_pkg::tcp_flags_t  o_flags,
    output tcp_pkg::window_t     o_window_size,
    output logic                 o_hdr_valid,

    output stream_pkg::byte_t    o_pl_data,
    output logic                 o_pl_valid,
    output logic                 o_pl_last,
    input  logic                 i_pl_ready,

    input  logic                 i_packet_done
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_SYN,
        SEND_ACK,
        SEND_FIN,
        SEND_DATA
    } state_t;

    state_t               state;
    state_t               state_next;
    tcp_pkg::seq_num_t    seq_num;
    tcp_pkg::seq_num_t    seq_num_next;
    stream_pkg::pkt_len_t pl_len;
    logic                 burst_in_done;
    logic                 pl_gate;
    logic                 pipe_ready;
    logic                 s_xfer;

    // payload only enters once a data segment is chosen, and one burst per segment.
    assign pl_gate   = (state == SEND_DATA) && !burst_in_done;
    assign o_s_ready = pipe_ready && pl_gate;
    assign s_xfer    = i_s_valid && o_s_ready;

    stream_pipe_reg u_pl_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_s_data),
        .i_valid (i_s_valid && pl_gate),
        .i_last  (i_s_last),
        .o_ready (pipe_ready),
        .o_data  (o_pl_data),
        .o_valid (o_pl_valid),
        .o_last  (o_pl_last),
        .i_ready (i_pl_ready)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= IDLE;
            seq_num       <= '0;
            burst_in_done <= 1'b0;
        end else begin
            state   <= state_next;
            seq_num <= seq_num_next;
            if (state == IDLE) begin
                burst_in_done <= 1'b0;
            end else if (s_xfer && i_s_last) begin
                burst_in_done <= 1'b1;
            end
        end
    end

    // i_s_len may change after the last byte, so keep the value seen when leaving idle.
    always_ff @(posedge i_clk) begin
        if (state == IDLE) begin
            pl_len <= i_s_len;
        end
    end

    always_comb begin
        state_next    = state;
        seq_num_next  = seq_num;
        o_tx_ctrl_ack = 1'b0;
        o_no_data     = 1'b1;
        o_flags       = '0;
        o_ip_len      = stream_pkg::pkt_len_t'(tcp_pkg::IP_TCP_HDR_LEN);

        case (state)
            IDLE: begin
                if (i_tx_ctrl_valid) begin    // command wins over payload.
                    o_tx_ctrl_ack = 1'b1;
                    case (i_tx_ctrl)
                        tcp_pkg::TX_CTRL_SEND_SYN: state_next = SEND_SYN;
                        tcp_pkg::TX_CTRL_SEND_ACK: state_next = SEND_ACK;
                        tcp_pkg::TX_CTRL_SEND_FIN: state_next = SEND_FIN;
                        default:                   state_next = IDLE;
                    endcase
                end else if (i_s_valid) begin
                    state_next = SEND_DATA;
                end
            end
            SEND_SYN: begin
                o_flags = tcp_pkg::FLAG_SYN;
                if (i_packet_done) begin
                    state_next   = IDLE;
                    seq_num_next = seq_num + 32'd1;    // syn uses one number.
                end
            end
            SEND_ACK: begin
                o_flags = tcp_pkg::FLAG_ACK;
                if (i_packet_done) begin
                    state_next = IDLE;
                end
            end
            SEND_FIN: begin
                o_flags = tcp_pkg::FLAG_ACK | tcp_pkg::FLAG_FIN;
                if (i_packet_done) begin
                    state_next   = IDLE;
                    seq_num_next = seq_num + 32'd1;
                end
            end
            SEND_DATA: begin
                o_flags   = tcp_pkg::FLAG_ACK | tcp_pkg::FLAG_PSH;
                o_no_data = 1'b0;
                o_ip_len  = stream_pkg::pkt_len_t'(tcp_pkg::IP_TCP_HDR_LEN) + pl_len;
                if (i_packet_done) begin
                    state_next   = IDLE;
                    seq_num_next = seq_num + tcp_pkg::seq_num_t'(pl_len);
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign o_hdr_valid   = (state != IDLE);
    assign o_seq_number  = seq_num;
    assign o_ack_number  = i_ack_number;    // from the receive side, passed as is.
    assign o_window_size = WINDOW_SIZE;

endmodule

// ==== tcp_tx/tcp_hdr_serializer.sv ====
module tcp_hdr_serializer #(
    parameter tcp_pkg::tcp_port_t SRC_PORT = 16'h1234,
    parameter tcp_pkg::tcp_port_t DST_PORT = 16'h0050
) (
    input  logic                i_clk,
    input  logic                i_rst,

    input  logic                i_hdr_valid,
    input  logic                i_no_data,
    input  tcp_pkg::seq_num_t   i_seq_number,
    input  tcp_pkg::seq_num_t   i_ack_number,
    input  tcp_pkg::tcp_flags_t i_flags,
    input  tcp_pkg::window_t    i_window_size,

    input  stream_pkg::byte_t   i_pl_data,
    input  logic                i_pl_valid,
    input  logic                i_pl_last,
    output logic                o_pl_ready,

    output stream_pkg::byte_t   o_m_data,
    output logic                o_m_valid,
    output logic                o_m_last,
    input  logic                i_m_ready,

    output logic                o_packet_done
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD,
        DONE
    } state_t;

    localparam stream_pkg::byte_t DATA_OFFSET = 8'h50;    // five words, no options.
    localparam int HDR_BITS = tcp_pkg::TCP_HDR_BYTES * 8;
    localparam logic [4:0] LAST_HDR_IDX = 5'(tcp_pkg::TCP_HDR_BYTES - 1);

    state_t                  state;
    state_t                  state_next;
    logic [4:0]              byte_cnt;
    logic                    no_data_q;
    tcp_pkg::seq_num_t       seq_q;
    tcp_pkg::seq_num_t       ack_q;
    tcp_pkg::tcp_flags_t     flags_q;
    tcp_pkg::window_t        window_q;
    logic [HDR_BITS-1:0]     hdr_vec;
    stream_pkg::byte_t       hdr_byte;
    logic                    hdr_end;

    // checksum and urgent pointer are sent as zero.
    assign hdr_vec = {SRC_PORT, DST_PORT, seq_q, ack_q, DATA_OFFSET, flags_q, window_q,
                      16'h0000, 16'h0000};
    assign hdr_byte = hdr_vec[(tcp_pkg::TCP_HDR_BYTES - 1 - int'(byte_cnt)) * 8 +: 8];
    assign hdr_end  = (byte_cnt == LAST_HDR_IDX);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= IDLE;
            byte_cnt <= '0;
        end else begin
            state <= state_next;
            if (state != HEADER) begin
                byte_cnt <= '0;
            end else if (i_m_ready) begin    // counter stalls under back-pressure.
                byte_cnt <= byte_cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_hdr_valid) begin
            no_data_q <= i_no_data;
            seq_q     <= i_seq_number;
            ack_q     <= i_ack_number;
            flags_q   <= i_flags;
            window_q  <= i_window_size;
        end
    end

    always_comb begin
        state_next    = state;
        o_m_data      = hdr_byte;
        o_m_valid     = 1'b0;
        o_m_last      = 1'b0;
        o_pl_ready    = 1'b0;
        o_packet_done = 1'b0;

        case (state)
            IDLE: begin
                if (i_hdr_valid) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                o_m_valid = 1'b1;
                o_m_last  = hdr_end && no_data_q;
                if (i_m_ready && hdr_end) begin
                    o_packet_done = no_data_q;
                    state_next    = no_data_q ? DONE : PAYLOAD;
                end
            end
            PAYLOAD: begin
                o_m_data   = i_pl_data;
                o_m_valid  = i_pl_valid;
                o_m_last   = i_pl_last;
                o_pl_ready = i_m_ready;
                if (i_pl_valid && i_m_ready && i_pl_last) begin
                    o_packet_done = 1'b1;
                    state_next    = DONE;
                end
            end
            DONE: begin
                // controller drops hdr_valid here.
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// ==== src/tcp_tx_top.sv ====
module tcp_tx_top #(
    parameter tcp_pkg::tcp_port_t SRC_PORT    = 16'h1234,
    parameter tcp_pkg::tcp_port_t DST_PORT    = 16'h0050,
    parameter tcp_pkg::window_t   WINDOW_SIZE = 16'd256
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::tx_ctrl_t    i_tx_ctrl,
    input  logic                 i_tx_ctrl_valid,
    output logic                 o_tx_ctrl_ack,

    input  tcp_pkg::seq_num_t    i_ack_number,

    input  stream_pkg::byte_t    i_s_data,
    input  logic                 i_s_valid,
    input  logic                 i_s_last,
    input  stream_pkg::pkt_len_t i_s_len,
    output logic                 o_s_ready,

    output stream_pkg::byte_t    o_m_data,
    output logic                 o_m_valid,
    output logic                 o_m_last,
    input  logic                 i_m_ready,

    output stream_pkg::pkt_len_t o_ip_len,
    output logic                 o_no_data,
    output logic                 o_hdr_valid
);

    tcp_pkg::seq_num_t   seq_number;
    tcp_pkg::seq_num_t   ack_number;
    tcp_pkg::tcp_flags_t flags;
    tcp_pkg::window_t    window_size;
    stream_pkg::byte_t   pl_data;
    logic                pl_valid;
    logic                pl_last;
    logic                pl_ready;
    logic                packet_done;

    tcp_tx_ctrl #(
        .WINDOW_SIZE (WINDOW_SIZE)
    ) u_tx_ctrl (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tx_ctrl       (i_tx_ctrl),
        .i_tx_ctrl_valid (i_tx_ctrl_valid),
        .o_tx_ctrl_ack   (o_tx_ctrl_ack),
        .i_ack_number    (i_ack_number),
        .i_s_data        (i_s_data),
        .i_s_valid       (i_s_valid),
        .i_s_last        (i_s_last),
        .i_s_len         (i_s_len),
        .o_s_ready       (o_s_ready),
        .o_no_data       (o_no_data),
        .o_ip_len        (o_ip_len),
        .o_seq_number    (seq_number),
        .o_ack_number    (ack_number),
        .o_flags         (flags),
        .o_window_size   (window_size),
        .o_hdr_valid     (o_hdr_valid),
        .o_pl_data       (pl_data),
        .o_pl_valid      (pl_valid),
        .o_pl_last       (pl_last),
        .i_pl_ready      (pl_ready),
        .i_packet_done   (packet_done)
    );

    tcp_hdr_serializer #(
        .SRC_PORT (SRC_PORT),
        .DST_PORT (DST_PORT)
    ) u_hdr_ser (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_hdr_valid   (o_hdr_valid),
        .i_no_data     (o_no_data),
        .i_seq_number  (seq_number),
        .i_ack_number  (ack_number),
        .i_flags       (flags),
        .i_window_size (window_size),
        .i_pl_data     (pl_data),
        .i_pl_valid    (pl_valid),
        .i_pl_last     (pl_last),
        .o_pl_ready    (pl_ready),
        .o_m_data      (o_m_data),
        .o_m_valid     (o_m_valid),
        .o_m_last      (o_m_last),
        .i_m_ready     (i_m_ready),
        .o_packet_done (packet_done)
    );

endmodule

// ==== test/tcp_tx_props.sv ====
module tcp_tx_props (
    input  logic              i_clk,
    input  logic              i_rst,
    input  stream_pkg::byte_t i_m_data,
    input  logic              i_m_valid,
    input  logic              i_m_last,
    input  logic              i_m_ready,
    input  logic              i_tx_ctrl_ack
);

    int err_count = 0;    // failed assertions so far.

    // a stalled output byte must be held until it is taken.
    property m_hold_p;
        @(posedge i_clk) disable iff (i_rst)
        (i_m_valid && !i_m_ready) |=>
            (i_m_valid && $stable(i_m_data) && $stable(i_m_last));
    endproperty

    property ack_pulse_p;
        @(posedge i_clk) disable iff (i_rst)
        i_tx_ctrl_ack |=> !i_tx_ctrl_ack;
    endproperty

    property reset_idle_p;
        @(posedge i_clk) i_rst |=> !i_m_valid;
    endproperty

    assert property (m_hold_p) else begin
        $error("output byte changed while stalled.");
        err_count++;
    end
    assert property (ack_pulse_p) else begin
        $error("command ack longer than one cycle.");
        err_count++;
    end
    assert property (reset_idle_p) else begin
        $error("output valid high right after reset.");
        err_count++;
    end

endmodule

bind tcp_tx_top tcp_tx_props u_props (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_m_data      (o_m_data),
    .i_m_valid     (o_m_valid),
    .i_m_last      (o_m_last),
    .i_m_ready     (i_m_ready),
    .i_tx_ctrl_ack (o_tx_ctrl_ack)
);

// ==== test/tcp_tx_tb.sv ====
module tcp_tx_tb;

    localparam logic [15:0] SRC_PORT    = 16'h1234;
    localparam logic [15:0] DST_PORT    = 16'h0050;
    localparam logic [15:0] WINDOW_SIZE = 16'd256;
    localparam int N_TESTS    = 7;
    localparam int MAX_CYCLES = 2000;    // per test.
    localparam int K_SYN  = 0;
    localparam int K_ACK  = 1;
    localparam int K_FIN  = 2;
    localparam int K_DATA = 3;

    logic                 i_clk = 1'b0;
    logic                 i_rst;
    tcp_pkg::tx_ctrl_t    i_tx_ctrl;
    logic                 i_tx_ctrl_valid;
    logic                 o_tx_ctrl_ack;
    tcp_pkg::seq_num_t    i_ack_number;
    stream_pkg::byte_t    i_s_data;
    logic                 i_s_valid;
    logic                 i_s_last;
    stream_pkg::pkt_len_t i_s_len;
    logic                 o_s_ready;
    stream_pkg::byte_t    o_m_data;
    logic                 o_m_valid;
    logic                 o_m_last;
    logic                 i_m_ready;
    stream_pkg::pkt_len_t o_ip_len;
    logic                 o_no_data;
    logic                 o_hdr_valid;

    // test table, one row per test.
    string       t_name [N_TESTS];
    int          t_kind [N_TESTS];
    int          t_len  [N_TESTS];
    logic [31:0] t_ack  [N_TESTS];
    bit          t_both [N_TESTS];    // command and payload offered together.
    bit          t_bp   [N_TESTS];

    integer      seed = 89;
    logic [31:0] model_seq;
    logic [7:0]  pl_bytes  [$];
    logic [7:0]  exp_bytes [$];
    logic [7:0]  got_bytes [$];
    int          test_errs;
    int          total_errs;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    always #20 i_clk = ~i_clk;

    tcp_tx_top #(
        .SRC_PORT    (SRC_PORT),
        .DST_PORT    (DST_PORT),
        .WINDOW_SIZE (WINDOW_SIZE)
    ) u_tcp_tx_top (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tx_ctrl       (i_tx_ctrl),
        .i_tx_ctrl_valid (i_tx_ctrl_valid),
        .o_tx_ctrl_ack   (o_tx_ctrl_ack),
        .i_ack_number    (i_ack_number),
        .i_s_data        (i_s_data),
        .i_s_valid       (i_s_valid),
        .i_s_last        (i_s_last),
        .i_s_len         (i_s_len),
        .o_s_ready       (o_s_ready),
        .o_m_data        (o_m_data),
        .o_m_valid       (o_m_valid),
        .o_m_last        (o_m_last),
        .i_m_ready       (i_m_ready),
        .o_ip_len        (o_ip_len),
        .o_no_data       (o_no_data),
        .o_hdr_valid     (o_hdr_valid)
    );

    task automatic set_entry(input int idx, input string name, input int kind, input int len,
                             input logic [31:0] ack, input bit both, input bit bp);
        t_name[idx] = name;
        t_kind[idx] = kind;
        t_len[idx]  = len;
        t_ack[idx]  = ack;
        t_both[idx] = both;
        t_bp[idx]   = bp;
    endtask

    function automatic logic [7:0] flags_of(input int kind);
        case (kind)
            K_SYN:   flags_of = 8'h02;
            K_ACK:   flags_of = 8'h10;
            K_FIN:   flags_of = 8'h11;
            default: flags_of = 8'h18;    // ack with psh.
        endcase
    endfunction

    function automatic tcp_pkg::tx_ctrl_t command_for(input int kind);
        case (kind)
            K_SYN:   command_for = tcp_pkg::TX_CTRL_SEND_SYN;
            K_ACK:   command_for = tcp_pkg::TX_CTRL_SEND_ACK;
            default: command_for = tcp_pkg::TX_CTRL_SEND_FIN;
        endcase
    endfunction

    task automatic build_expected(input int kind, input logic [31:0] ack);
        logic [159:0] hdr;
        hdr = {SRC_PORT, DST_PORT, model_seq, ack, 8'h50, flags_of(kind), WINDOW_SIZE, 32'h0};
        exp_bytes.delete();
        for (int k = 0; k < 20; k++) begin
            exp_bytes.push_back(hdr[159 - 8 * k -: 8]);    // network byte order.
        end
        if (kind == K_DATA) begin
            foreach (pl_bytes[i]) exp_bytes.push_back(pl_bytes[i]);
        end
    endtask

    task automatic check_segment(input string name, input int kind, input int len);
        if (got_bytes.size() != exp_bytes.size()) begin
            $display("ERROR %s: segment length expected %0d actual %0d",
                     name, exp_bytes.size(), got_bytes.size());
            test_errs++;
        end
        for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++) begin
            if (got_bytes[i] != exp_bytes[i]) begin
                $display("ERROR %s: byte %0d expected 0x%02h actual 0x%02h",
                         name, i, exp_bytes[i], got_bytes[i]);
                test_errs++;
            end
        end
        if (kind == K_SYN || kind == K_FIN) begin
            model_seq = model_seq + 32'd1;
        end else if (kind == K_DATA) begin
            model_seq = model_seq + 32'(len);
        end
    endtask

    task automatic run_test(input int idx);
        int       kind_now;
        int       seg_left;
        int       pl_idx;
        int       cycles;
        int       len;
        bit       side_seen;
        logic [15:0] exp_len;
        len = t_len[idx];
        pl_bytes.delete();
        got_bytes.delete();
        for (int i = 0; i < len; i++) pl_bytes.push_back(8'($random(seed)));
        kind_now = t_kind[idx];    // control segment goes first when both are offered.
        seg_left = t_both[idx] ? 2 : 1;
        build_expected(kind_now, t_ack[idx]);

        @(posedge i_clk);
        i_ack_number <= t_ack[idx];
        i_s_len      <= 16'(len);
        if (kind_now != K_DATA) begin
            i_tx_ctrl       <= command_for(kind_now);
            i_tx_ctrl_valid <= 1'b1;
        end
        if (len > 0) begin
            i_s_valid <= 1'b1;
            i_s_data  <= pl_bytes[0];
            i_s_last  <= (len == 1);
        end
        i_m_ready <= t_bp[idx] ? 1'($random(seed)) : 1'b1;

        cycles    = 0;
        pl_idx    = 0;
        side_seen = 1'b0;
        while (seg_left > 0 && cycles < MAX_CYCLES) begin
            @(posedge i_clk);
            cycles++;
            if (i_tx_ctrl_valid && o_tx_ctrl_ack) begin
                i_tx_ctrl_valid <= 1'b0;
            end
            if (i_s_valid && o_s_ready) begin
                pl_idx++;
                if (pl_idx == len) begin
                    i_s_valid <= 1'b0;
                end else begin
                    i_s_data <= pl_bytes[pl_idx];
                    i_s_last <= (pl_idx == len - 1);
                end
            end
            if (o_hdr_valid && !side_seen) begin
                side_seen = 1'b1;
                exp_len   = 16'(40 + ((kind_now == K_DATA) ? len : 0));
                if (o_ip_len != exp_len) begin
                    $display("ERROR %s: ip length expected %0d actual %0d",
                             t_name[idx], exp_len, o_ip_len);
                    test_errs++;
                end
                if (o_no_data != (kind_now != K_DATA)) begin
                    $display("ERROR %s: no_data expected %0b actual %0b",
                             t_name[idx], (kind_now != K_DATA), o_no_data);
                    test_errs++;
                end
            end
            if (o_m_valid && i_m_ready) begin
                got_bytes.push_back(o_m_data);
                if (o_m_last) begin
                    check_segment(t_name[idx], kind_now, len);
                    seg_left--;
                    kind_now  = K_DATA;
                    side_seen = 1'b0;
                    got_bytes.delete();
                    build_expected(K_DATA, t_ack[idx]);
                end
            end
            if (t_bp[idx]) begin
                i_m_ready <= 1'($random(seed));
            end
        end
        if (seg_left > 0) begin
            $display("timeout: test %s did not finish its segments within %0d cycles",
                     t_name[idx], MAX_CYCLES);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        i_rst           = 1'b1;
        i_tx_ctrl       = tcp_pkg::TX_CTRL_NONE;
        i_tx_ctrl_valid = 1'b0;
        i_ack_number    = '0;
        i_s_data        = '0;
        i_s_valid       = 1'b0;
        i_s_last        = 1'b0;
        i_s_len         = '0;
        i_m_ready       = 1'b1;
        model_seq       = '0;
        total_errs      = 0;
        pass_count      = 0;
        fail_count      = 0;
        timed_out       = 1'b0;

        set_entry(0, "syn_after_reset", K_SYN,  0,  32'h0000_0000, 1'b0, 1'b0);
        set_entry(1, "ack_plain",       K_ACK,  0,  32'hA1B2_C3D4, 1'b0, 1'b0);
        set_entry(2, "data_16",         K_DATA, 16, 32'hA1B2_C3D4, 1'b0, 1'b0);
        set_entry(3, "fin",             K_FIN,  0,  32'h0000_1001, 1'b0, 1'b0);
        set_entry(4, "data_bp_37",      K_DATA, 37, 32'h0000_1002, 1'b0, 1'b1);
        set_entry(5, "ack_with_data",   K_ACK,  8,  32'h0BAD_F00D, 1'b1, 1'b0);
        set_entry(6, "data_bp_1",       K_DATA, 1,  32'h0BAD_F00E, 1'b0, 1'b1);

        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        if (o_m_valid || o_hdr_valid || o_tx_ctrl_ack || o_s_ready) begin
            $display("ERROR reset_outputs: active outputs expected 0000 actual %b%b%b%b",
                     o_m_valid, o_hdr_valid, o_tx_ctrl_ack, o_s_ready);
            $display("test reset_outputs failed");
            fail_count++;
        end else begin
            $display("test reset_outputs passed");
            pass_count++;
        end

        for (int i = 0; i < N_TESTS && !timed_out; i++) begin
            test_errs = 0;
            run_test(i);
            total_errs += test_errs;
            if (timed_out || test_errs != 0) begin
                $display("test %s failed with %0d errors", t_name[i], test_errs);
                fail_count++;
            end else begin
                $display("test %s passed", t_name[i]);
                pass_count++;
            end
        end

        $display("summary: %0d passed, %0d failed, %0d value errors, %0d assertion failures",
                 pass_count, fail_count, total_errs, u_tcp_tx_top.u_props.err_count);
        if (fail_count == 0 && !timed_out && u_tcp_tx_top.u_props.err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/tcp_pkg.sv
common/stream_pkg.sv
src/stream_pipe_reg.sv
tcp_tx/tcp_tx_ctrl.sv
tcp_tx/tcp_hdr_serializer.sv
src/tcp_tx_top.sv
test/tcp_tx_props.sv
test/tcp_tx_tb.sv
